// ==== core_perf_monitor.f ====
+incdir+rtl
rtl/perf_event_pkg.sv
rtl/perf_csr_pkg.sv
rtl/perf_event_decode.sv
rtl/perf_counter_exec.sv
rtl/perf_csr_result.sv
rtl/core_perf_monitor.sv
sim/tb_clock_gen.sv
sim/tb_core_perf_monitor.sv

// ==== Makefile ====
BIN  := obj_dir/Vtb_core_perf_monitor
SRCS := $(shell grep -v '^+' core_perf_monitor.f) rtl/perf_macros.svh

.PHONY: all run clean

all: run

$(BIN): core_perf_monitor.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal \
		--top-module tb_core_perf_monitor -f core_perf_monitor.f

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'No errors'

clean:
	rm -rf obj_dir

// ==== sim/tb_core_perf_monitor.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "perf_macros.svh"

module tb_core_perf_monitor;
    import perf_event_pkg::*;
    import perf_csr_pkg::*;

    localparam int CLK_PERIOD_NS  = 4;
    localparam int RANDOM_CYCLES  = 200;
    localparam int SHORT_CYCLES   = 50;
    localparam int ACCESS_CYCLES  = 3;
    localparam int COMPARE_CYCLES = 3 + 5 * ACCESS_CYCLES;
    localparam int ACK_TIMEOUT    = 8;
    // each random test is traffic plus a drain of at most the same length
    localparam int BUDGET_CYCLES  = 4 + COMPARE_CYCLES
        + 2 * (2 * RANDOM_CYCLES + COMPARE_CYCLES)
        + 8 + COMPARE_CYCLES
        + 5 * ACCESS_CYCLES + 3 * COMPARE_CYCLES + 2 * SHORT_CYCLES;
    localparam int MARGIN_CYCLES  = 100;

    logic                          clk;
    logic                          reset;
    fetch_probe_t                  fetch_probe;
    data_probe_t [`DATA_LANES-1:0] data_probe;
    logic                          wb_cyc;
    logic                          wb_stb;
    logic                          wb_we;
    logic [`WB_ADDR_BITS-1:0]      wb_adr;
    logic [`WB_DATA_BITS-1:0]      wb_dat_w;
    logic [`WB_DATA_BITS-1:0]      wb_dat_r;
    logic                          wb_ack;

    // expected register values by word address
    int unsigned exp_ctr [5] = '{default: 0};
    // fire cycles of outstanding reads with the oldest first
    int unsigned fetch_q [$];
    int unsigned load_q [$];
    int unsigned cycle = 0;
    logic [31:0] rng_state = 32'd86;
    logic        compare_busy = 1'b0;
    int          errors = 0;
    int          test_errors = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;
    string       test_name;

    tb_clock_gen #(.PERIOD_NS(CLK_PERIOD_NS), .RESET_CYCLES(2)) clock_gen_i (
        .clk   (clk),
        .reset (reset)
    );

    core_perf_monitor core_perf_monitor_i (
        .clk         (clk),
        .reset       (reset),
        .fetch_probe (fetch_probe),
        .data_probe  (data_probe),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_adr      (wb_adr),
        .wb_dat_w    (wb_dat_w),
        .wb_dat_r    (wb_dat_r),
        .wb_ack      (wb_ack)
    );

    always @(posedge clk) cycle <= cycle + 1;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic void count_error();
        errors++;
        test_errors++;
    endfunction

    function automatic void check_value(input string name, input int unsigned expected,
                                        input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("[FAIL] %0t %s expected %0d got %0d", $time, name, expected, actual);
            count_error();
        end
    endfunction

    // reference model fed with the fires of one cycle
    function automatic void predict_cycle(input int unsigned now, input bit fetch_req,
                                          input bit fetch_rsp, input int unsigned n_load,
                                          input int unsigned n_store, input int unsigned n_rsp);
        // a response closes the oldest read and adds b - a
        if (fetch_rsp)
            exp_ctr[REG_IFETCH_LAT] += now - fetch_q.pop_front();
        for (int k = 0; k < n_rsp; k++)
            exp_ctr[REG_LOAD_LAT] += now - load_q.pop_front();
        if (fetch_req) begin
            exp_ctr[REG_IFETCHES] += 1;
            fetch_q.push_back(now);
        end
        for (int k = 0; k < n_load; k++)
            load_q.push_back(now);
        exp_ctr[REG_LOADS]  += n_load;
        exp_ctr[REG_STORES] += n_store;
    endfunction

    function automatic void clear_expected();
        exp_ctr = '{default: 0};
        fetch_q.delete();
        load_q.delete();
    endfunction

    // called on a falling edge and returns on the next one
    task automatic drive_cycle(input fetch_probe_t fp, input data_probe_t [`DATA_LANES-1:0] dp);
        int unsigned n_load;
        int unsigned n_store;
        int unsigned n_rsp;
        n_load = 0;
        n_store = 0;
        n_rsp = 0;
        fetch_probe = fp;
        data_probe = dp;
        for (int i = 0; i < `DATA_LANES; i++) begin
            if (dp[i].req_valid && dp[i].req_ready) begin
                if (dp[i].req_rw)
                    n_store++;
                else
                    n_load++;
            end
            if (dp[i].rsp_valid && dp[i].rsp_ready)
                n_rsp++;
        end
        predict_cycle(cycle, fp.req_valid && fp.req_ready, fp.rsp_valid && fp.rsp_ready,
                      n_load, n_store, n_rsp);
        @(negedge clk);
    endtask

    // answer every outstanding read with one response per lane per cycle
    task automatic drain_responses();
        fetch_probe_t                  fp;
        data_probe_t [`DATA_LANES-1:0] dp;
        int                            avail;
        while (fetch_q.size() > 0 || load_q.size() > 0) begin
            fp = '0;
            dp = '0;
            fp.rsp_valid = fetch_q.size() > 0;
            fp.rsp_ready = fp.rsp_valid;
            avail = load_q.size();
            for (int i = 0; i < `DATA_LANES; i++) begin
                dp[i].rsp_valid = avail > 0;
                dp[i].rsp_ready = avail > 0;
                if (avail > 0)
                    avail--;
            end
            drive_cycle(fp, dp);
        end
    endtask

    task automatic random_traffic(input int n_cycles, input bit use_fetch, input bit use_data);
        fetch_probe_t                  fp;
        data_probe_t [`DATA_LANES-1:0] dp;
        logic [31:0]                   r;
        int                            avail;
        for (int c = 0; c < n_cycles; c++) begin
            fp = '0;
            dp = '0;
            if (use_fetch) begin
                r = next_rand();
                fp.req_valid = r[0];
                fp.req_ready = r[1] | r[2];
                fp.rsp_valid = (fetch_q.size() > 0) && r[3];
                fp.rsp_ready = r[4] | r[5];
            end
            if (use_data) begin
                avail = load_q.size();
                for (int i = 0; i < `DATA_LANES; i++) begin
                    r = next_rand();
                    dp[i].req_valid = r[0];
                    dp[i].req_ready = r[1] | r[2];
                    dp[i].req_rw    = r[3];
                    dp[i].rsp_ready = r[4] | r[5];
                    dp[i].rsp_valid = (avail > 0) && r[6];
                    if (dp[i].rsp_valid && dp[i].rsp_ready)
                        avail--;
                end
            end
            drive_cycle(fp, dp);
        end
        drain_responses();
    endtask

    // one classic cycle with the strobe held through the ack cycle
    task automatic wb_access(input logic we, input int word, input logic [31:0] wdata,
                             output logic [31:0] rdata);
        int waited;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we = we;
        wb_adr = `WB_ADDR_BITS'(word * 4);
        wb_dat_w = wdata;
        @(negedge clk);
        waited = 1;
        while (!wb_ack && waited < ACK_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        rdata = wb_dat_r;
        assert (wb_ack && waited == 1) else begin
            $display("no ack one cycle after access to word %0d (waited %0d cycles)",
                     word, waited);
            count_error();
        end
        @(negedge clk);
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        assert (!wb_ack) else begin
            $display("ack for word %0d stayed high longer than one cycle", word);
            count_error();
        end
    endtask

    task automatic request_compare();
        compare_busy = 1'b1;
        wait (!compare_busy);
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        if (test_errors == 0) begin
            tests_passed++;
            $display("test %s: pass", test_name);
        end else begin
            tests_failed++;
            $display("test %s: fail, %0d mismatches", test_name, test_errors);
        end
    endtask

    // settle with an idle bus and read back all five counters
    initial begin : compare_proc
        logic [31:0] rdata;
        perf_reg_e   reg_id;
        forever begin
            wait (compare_busy);
            fetch_probe = '0;
            data_probe = '0;
            repeat (3) @(negedge clk);
            for (int r = 0; r < 5; r++) begin
                reg_id = perf_reg_e'(r);
                wb_access(1'b0, r, '0, rdata);
                check_value(reg_id.name(), exp_ctr[r], rdata);
            end
            compare_busy = 1'b0;
        end
    end

    initial begin : watchdog
        #((BUDGET_CYCLES + MARGIN_CYCLES) * CLK_PERIOD_NS);
        $display("timeout: the run went past its cycle budget");
        $display("Errors found");
        $finish;
    end

    initial begin : main_seq
        fetch_probe_t                  fp;
        data_probe_t [`DATA_LANES-1:0] dp;
        logic [31:0]                   rdata;
        fetch_probe = '0;
        data_probe = '0;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_dat_w = '0;
        wait (reset == 1'b0);
        @(negedge clk);

        begin_test("reset values");
        request_compare();
        end_test();

        begin_test("random fetch traffic");
        random_traffic(RANDOM_CYCLES, 1'b1, 1'b0);
        request_compare();
        end_test();

        begin_test("random loads and stores");
        random_traffic(RANDOM_CYCLES, 1'b0, 1'b1);
        request_compare();
        end_test();

        // valid held three cycles before ready while a store on lane 1 never fires
        begin_test("back-pressure");
        fp = '0;
        dp = '0;
        fp.req_valid = 1'b1;
        dp[0].req_valid = 1'b1;
        dp[1].req_valid = 1'b1;
        dp[1].req_rw = 1'b1;
        repeat (3) drive_cycle(fp, dp);
        fp.req_ready = 1'b1;
        dp[0].req_ready = 1'b1;
        drive_cycle(fp, dp);
        fp = '0;
        dp = '0;
        fp.rsp_valid = 1'b1;
        dp[1].rsp_valid = 1'b1;
        repeat (3) drive_cycle(fp, dp);
        fp.rsp_ready = 1'b1;
        dp[1].rsp_ready = 1'b1;
        drive_cycle(fp, dp);
        request_compare();
        end_test();

        begin_test("clear and readout of unmapped words");
        wb_access(1'b1, REG_LOADS, 32'hffff_ffff, rdata);
        request_compare();
        wb_access(1'b1, REG_CLEAR, 32'h1, rdata);
        clear_expected();
        request_compare();
        random_traffic(SHORT_CYCLES, 1'b1, 1'b1);
        request_compare();
        wb_access(1'b0, REG_CLEAR, '0, rdata);
        check_value("REG_CLEAR", 0, rdata);
        wb_access(1'b0, 6, '0, rdata);
        check_value("word 6", 0, rdata);
        wb_access(1'b0, 63, '0, rdata);
        check_value("word 63", 0, rdata);
        end_test();

        $display("tests passed %0d, tests failed %0d, mismatches %0d",
                 tests_passed, tests_failed, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 4,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic reset
);
    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // release away from the rising edge
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

`default_nettype wire

// ==== rtl/core_perf_monitor.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "perf_macros.svh"

module core_perf_monitor (
    input  logic                                          clk,
    input  logic                                          reset,
    input  perf_event_pkg::fetch_probe_t                  fetch_probe,
    input  perf_event_pkg::data_probe_t [`DATA_LANES-1:0] data_probe,
    input  logic                                          wb_cyc,
    input  logic                                          wb_stb,
    input  logic                                          wb_we,
    input  logic [`WB_ADDR_BITS-1:0]                      wb_adr,
    input  logic [`WB_DATA_BITS-1:0]                      wb_dat_w,
    output logic [`WB_DATA_BITS-1:0]                      wb_dat_r,
    output logic                                          wb_ack
);
    import perf_event_pkg::*;
    import perf_csr_pkg::*;

    perf_events_t   events;
    perf_counters_t counters;
    logic           clear;

    // bus handshakes to per-cycle event counts
    perf_event_decode decode_i (
        .clk         (clk),
        .reset       (reset),
        .fetch_probe (fetch_probe),
        .data_probe  (data_probe),
        .events      (events)
    );

    // trackers and accumulators
    perf_counter_exec exec_i (
        .clk      (clk),
        .reset    (reset),
        .events   (events),
        .clear    (clear),
        .counters (counters)
    );

    // software access to the counters
    perf_csr_result result_i (
        .clk      (clk),
        .reset    (reset),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .counters (counters),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .clear    (clear)
    );

endmodule

`default_nettype wire

// ==== rtl/perf_csr_result.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "perf_macros.svh"

module perf_csr_result (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         wb_cyc,
    input  logic                         wb_stb,
    input  logic                         wb_we,
    input  logic [`WB_ADDR_BITS-1:0]     wb_adr,
    input  logic [`WB_DATA_BITS-1:0]     wb_dat_w,
    input  perf_csr_pkg::perf_counters_t counters,
    output logic [`WB_DATA_BITS-1:0]     wb_dat_r,
    output logic                         wb_ack,
    output logic                         clear
);
    import perf_csr_pkg::*;

    wb_state_e                state;
    perf_reg_e                reg_sel;
    logic                     access;
    logic [`WB_DATA_BITS-1:0] rd_data;

    assign access  = (state == WB_IDLE) && wb_cyc && wb_stb;
    // drop the byte offset
    assign reg_sel = perf_reg_e'(wb_adr[`WB_ADDR_BITS-1:2]);

    always_comb begin
        case (reg_sel)
            REG_IFETCHES:   rd_data = `WB_DATA_BITS'(counters.ifetches);
            REG_LOADS:      rd_data = `WB_DATA_BITS'(counters.loads);
            REG_STORES:     rd_data = `WB_DATA_BITS'(counters.stores);
            REG_IFETCH_LAT: rd_data = `WB_DATA_BITS'(counters.ifetch_lat);
            REG_LOAD_LAT:   rd_data = `WB_DATA_BITS'(counters.load_lat);
            // clear and unmapped words read as zero
            default:        rd_data = '0;
        endcase
    end

    // accept in idle, ack the next cycle, back to idle
    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= WB_IDLE;
            wb_ack <= 1'b0;
            clear  <= 1'b0;
        end else begin
            case (state)
                WB_IDLE: begin
                    if (access) begin
                        state  <= WB_ACK;
                        wb_ack <= 1'b1;
                        clear  <= wb_we && (reg_sel == REG_CLEAR);
                    end
                end
                default: begin
                    state  <= WB_IDLE;
                    wb_ack <= 1'b0;
                    clear  <= 1'b0;
                end
            endcase
        end
    end

    // read data rides with the ack
    always_ff @(posedge clk) begin
        if (access) begin
            wb_dat_r <= rd_data;
        end
    end

    // ack answers an accepted strobe that the master still holds
    a_ack_after_accept: assert property (@(posedge clk) disable iff (reset)
        wb_ack |-> $past(access) && wb_cyc && wb_stb)
        else $error("wb_ack without an accepted cycle still held by the master");

    // master must present defined data on a write
    a_write_data_known: assert property (@(posedge clk) disable iff (reset)
        (access && wb_we) |-> !$isunknown(wb_dat_w))
        else $error("wishbone write with unknown data");

endmodule

`default_nettype wire

// ==== rtl/perf_counter_exec.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "perf_macros.svh"

module perf_counter_exec (
    input  logic                         clk,
    input  logic                         reset,
    input  perf_event_pkg::perf_events_t events,
    input  logic                         clear,
    output perf_csr_pkg::perf_counters_t counters
);
    // one spare bit so a tracker overflow is visible
    localparam int SUM_BITS = `PERF_CTR_BITS + 1;

    // reads issued but not yet answered
    logic [`PERF_CTR_BITS-1:0] pending_ifetch;
    logic [`PERF_CTR_BITS-1:0] pending_load;

    // tracker plus this cycle's requests
    logic [SUM_BITS-1:0] ifetch_sum;
    logic [SUM_BITS-1:0] load_sum;

    assign ifetch_sum = {1'b0, pending_ifetch} + SUM_BITS'(events.ifetch_req);
    assign load_sum   = {1'b0, pending_load} + SUM_BITS'(events.load_reqs);

    // pending trackers
    always_ff @(posedge clk) begin
        if (reset || clear) begin
            pending_ifetch <= '0;
            pending_load   <= '0;
        end else begin
            pending_ifetch <= `PERF_CTR_BITS'(ifetch_sum - SUM_BITS'(events.ifetch_rsp));
            pending_load   <= `PERF_CTR_BITS'(load_sum - SUM_BITS'(events.load_rsps));
        end
    end

    // event counters and latency sums
    always_ff @(posedge clk) begin
        if (reset || clear) begin
            counters <= '0;
        end else begin
            counters.ifetches <= counters.ifetches + `PERF_CTR_BITS'(events.ifetch_req);
            counters.loads    <= counters.loads + `PERF_CTR_BITS'(events.load_reqs);
            counters.stores   <= counters.stores + `PERF_CTR_BITS'(events.store_reqs);
            // old tracker value, so a read adds one per cycle it was outstanding
            counters.ifetch_lat <= counters.ifetch_lat + pending_ifetch;
            counters.load_lat   <= counters.load_lat + pending_load;
        end
    end

    // a response always has a read outstanding for it
    a_ifetch_no_underflow: assert property (@(posedge clk) disable iff (reset || clear)
        ifetch_sum >= SUM_BITS'(events.ifetch_rsp))
        else $error("ifetch response without an outstanding fetch");

    a_load_no_underflow: assert property (@(posedge clk) disable iff (reset || clear)
        load_sum >= SUM_BITS'(events.load_rsps))
        else $error("load response without an outstanding load");

    // trackers never wrap past all ones
    a_ifetch_no_wrap: assert property (@(posedge clk) disable iff (reset || clear)
        !ifetch_sum[SUM_BITS-1])
        else $error("pending ifetch tracker wrapped");

    a_load_no_wrap: assert property (@(posedge clk) disable iff (reset || clear)
        !load_sum[SUM_BITS-1])
        else $error("pending load tracker wrapped");

endmodule

`default_nettype wire

// ==== rtl/perf_event_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "perf_macros.svh"

module perf_event_decode (
    input  logic                                          clk,
    input  logic                                          reset,
    input  perf_event_pkg::fetch_probe_t                  fetch_probe,
    input  perf_event_pkg::data_probe_t [`DATA_LANES-1:0] data_probe,
    output perf_event_pkg::perf_events_t                  events
);
    import perf_event_pkg::*;

    logic                     ifetch_req_fire;
    logic                     ifetch_rsp_fire;
    logic [LANE_CNT_BITS-1:0] load_req_cnt;
    logic [LANE_CNT_BITS-1:0] store_req_cnt;
    logic [LANE_CNT_BITS-1:0] load_rsp_cnt;

    assign ifetch_req_fire = fetch_probe.req_valid && fetch_probe.req_ready;
    assign ifetch_rsp_fire = fetch_probe.rsp_valid && fetch_probe.rsp_ready;

    // population count of fires across the lanes
    always_comb begin
        load_req_cnt  = '0;
        store_req_cnt = '0;
        load_rsp_cnt  = '0;
        for (int i = 0; i < `DATA_LANES; i++) begin
            if (data_probe[i].req_valid && data_probe[i].req_ready) begin
                if (data_probe[i].req_rw) begin
                    store_req_cnt = store_req_cnt + 1'b1;
                end else begin
                    load_req_cnt = load_req_cnt + 1'b1;
                end
            end
            if (data_probe[i].rsp_valid && data_probe[i].rsp_ready) begin
                load_rsp_cnt = load_rsp_cnt + 1'b1;
            end
        end
    end

    // requests and responses take the same single stage
    always_ff @(posedge clk) begin
        if (reset) begin
            events <= '0;
        end else begin
            events.ifetch_req <= ifetch_req_fire;
            events.ifetch_rsp <= ifetch_rsp_fire;
            events.load_reqs  <= load_req_cnt;
            events.store_reqs <= store_req_cnt;
            events.load_rsps  <= load_rsp_cnt;
        end
    end

    // a lane offering a request must say whether it is a load or a store
    for (genvar i = 0; i < `DATA_LANES; i++) begin : g_rw_known
        a_rw_known: assert property (@(posedge clk) disable iff (reset)
            data_probe[i].req_valid |-> !$isunknown(data_probe[i].req_rw))
            else $error("lane %0d: req_rw unknown while req_valid", i);
    end

endmodule

`default_nettype wire

// ==== rtl/perf_csr_pkg.sv ====
`default_nettype none

`include "perf_macros.svh"

package perf_csr_pkg;

    // word address = byte address / 4
    localparam int REG_ADDR_BITS = `WB_ADDR_BITS - 2;

    // register map, word addresses
    typedef enum logic [REG_ADDR_BITS-1:0] {
        REG_IFETCHES   = 'd0,
        REG_LOADS      = 'd1,
        REG_STORES     = 'd2,
        REG_IFETCH_LAT = 'd3,
        REG_LOAD_LAT   = 'd4,
        REG_CLEAR      = 'd5
    } perf_reg_e;

    // slave handshake states
    typedef enum logic {
        WB_IDLE = 1'b0,
        WB_ACK  = 1'b1
    } wb_state_e;

    // counter bundle handed to the readout
    typedef struct packed {
        logic [`PERF_CTR_BITS-1:0] ifetches;
        logic [`PERF_CTR_BITS-1:0] loads;
        logic [`PERF_CTR_BITS-1:0] stores;
        // sums of pending reads, one term per cycle
        logic [`PERF_CTR_BITS-1:0] ifetch_lat;
        logic [`PERF_CTR_BITS-1:0] load_lat;
    } perf_counters_t;

endpackage

`default_nettype wire

// ==== rtl/perf_event_pkg.sv ====
`default_nettype none

`include "perf_macros.svh"

package perf_event_pkg;

    // per-cycle lane counts run 0..DATA_LANES
    localparam int LANE_CNT_BITS = $clog2(`DATA_LANES + 1);

    // instruction fetch bus handshake snapshot
    typedef struct packed {
        logic req_valid;
        logic req_ready;
        logic rsp_valid;
        logic rsp_ready;
    } fetch_probe_t;

    // one data-cache lane, req_rw high for a store
    typedef struct packed {
        logic req_valid;
        logic req_ready;
        logic req_rw;
        logic rsp_valid;
        logic rsp_ready;
    } data_probe_t;

    // registered events of one cycle
    typedef struct packed {
        logic                     ifetch_req;
        logic                     ifetch_rsp;
        logic [LANE_CNT_BITS-1:0] load_reqs;
        logic [LANE_CNT_BITS-1:0] store_reqs;
        logic [LANE_CNT_BITS-1:0] load_rsps;
    } perf_events_t;

endpackage

`default_nettype wire

// ==== rtl/perf_macros.svh ====
`ifndef PERF_MACROS_SVH
`define PERF_MACROS_SVH

// every counter and tracker is one word
`define PERF_CTR_BITS 32

// data-cache request lanes watched in parallel
`define DATA_LANES 2

// wishbone byte address and data widths
`define WB_ADDR_BITS 8
`define WB_DATA_BITS 32

`endif
